// File: vlog.f
+incdir+verification
common/isa_pkg.sv
common/ren_cfg_pkg.sv
rename/dep_bypass.sv
rename/spec_map_table.sv
rename/arch_map_table.sv
rename/free_list.sv
verilog/rename_stage.sv
verification/rename_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rename testbench, then scan the log for a failure
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module rename_tb -f vlog.f -o rename_sim \
    && ./obj_dir/rename_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q -F '*** FAILED ***' sim.log && exit 1
grep -q -F '*** PASSED ***' sim.log || exit 1
exit 0

// File: verification/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Speculative and committed register maps
int smap [ARCH_REG_COUNT];
int amap [ARCH_REG_COUNT];
// Free codes from the committed head up to the tail
int free_q [$];
// Codes handed out beyond the committed head
int spec_off;
// In-flight ops that own a destination, oldest first
int rob_arch [$];
int rob_phys [$];
// Code each requesting slot of the current group should receive
int req_codes [RENAME_WIDTH];

function automatic void reset_state();
    free_q.delete();
    rob_arch.delete();
    rob_phys.delete();
    for (int e = 0; e < FREE_DEPTH; e++) begin
        free_q.push_back(ARCH_REG_COUNT + e);
    end
    for (int r = 0; r < ARCH_REG_COUNT; r++) begin
        smap[r] = r;
        amap[r] = r;
    end
    spec_off = 0;
endfunction

// Requesters take consecutive free entries in slot order
function automatic int plan_alloc();
    int n;
    n = 0;
    for (int k = 0; k < RENAME_WIDTH; k++) begin
        req_codes[k] = -1;
        if (dec_vld[k] && dst_vld[k]) begin
            if (spec_off + n < free_q.size()) begin
                req_codes[k] = free_q[spec_off + n];
            end
            n++;
        end
    end
    return n;
endfunction

function automatic int expected_src(input int k, input int s);
    int code;
    code = smap[int'(src_arch[k][s])];
    // Youngest older producer in the group wins
    for (int j = 0; j < k; j++) begin
        if (dec_vld[j] && dst_vld[j] && dst_arch[j] == src_arch[k][s]) begin
            code = req_codes[j];
        end
    end
    return code;
endfunction

function automatic void commit_retires(input int n);
    int   code;
    logic shadowed;
    for (int i = 0; i < n; i++) begin
        shadowed = 1'b0;
        for (int j = i + 1; j < n; j++) begin
            if (rob_arch[j] == rob_arch[i]) begin
                shadowed = 1'b1;
            end
        end
        // A shadowed retire never reaches the map, so it frees its own code
        if (shadowed) begin
            code = rob_phys[i];
        end else begin
            code = amap[rob_arch[i]];
            amap[rob_arch[i]] = rob_phys[i];
        end
        free_q.push_back(code);
    end
    for (int i = 0; i < n; i++) begin
        void'(free_q.pop_front());
        void'(rob_arch.pop_front());
        void'(rob_phys.pop_front());
    end
    spec_off -= n;
endfunction

function automatic void accept_group();
    for (int k = 0; k < RENAME_WIDTH; k++) begin
        if (dec_vld[k] && dst_vld[k]) begin
            smap[int'(dst_arch[k])] = req_codes[k];
            rob_arch.push_back(int'(dst_arch[k]));
            rob_phys.push_back(req_codes[k]);
            spec_off++;
        end
    end
endfunction

function automatic void flush_state();
    smap = amap;
    spec_off = 0;
    rob_arch.delete();
    rob_phys.delete();
endfunction

`endif

// File: verification/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
    import isa_pkg::*;
    import ren_cfg_pkg::*;

    localparam int NUM_PHYS_REGS = DEF_NUM_PHYS_REGS;
    localparam int RENAME_WIDTH  = DEF_RENAME_WIDTH;
    localparam int RETIRE_WIDTH  = DEF_RETIRE_WIDTH;
    localparam int PHYS_BITS     = $clog2(NUM_PHYS_REGS);
    localparam int FREE_DEPTH    = NUM_PHYS_REGS - ARCH_REG_COUNT;

    // Cycle budgets per test
    localparam int DEP_CYCLES    = 200;
    localparam int STALL_CYCLES  = 200;
    localparam int RETIRE_CYCLES = 300;
    localparam int FLUSH_CYCLES  = 300;
    localparam int TOTAL_CYCLES  = 4 + 1 + DEP_CYCLES + STALL_CYCLES + RETIRE_CYCLES
                                 + FLUSH_CYCLES;
    localparam int WATCHDOG_NS   = TOTAL_CYCLES * 10 + 1000;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 dsp_stall;
    logic                 dec_vld   [RENAME_WIDTH];
    logic                 dst_vld   [RENAME_WIDTH];
    arch_reg_t            dst_arch  [RENAME_WIDTH];
    logic                 src_vld   [RENAME_WIDTH][SRCS_PER_UOP];
    arch_reg_t            src_arch  [RENAME_WIDTH][SRCS_PER_UOP];
    logic                 ret_vld   [RETIRE_WIDTH];
    arch_reg_t            ret_arch  [RETIRE_WIDTH];
    logic [PHYS_BITS-1:0] ret_phys  [RETIRE_WIDTH];
    logic [PHYS_BITS-1:0] src_phys  [RENAME_WIDTH][SRCS_PER_UOP];
    logic [PHYS_BITS-1:0] dst_phys  [RENAME_WIDTH];
    logic                 ren_stall;

    int   errors;
    int   checks;
    int   tests;
    int   ret_count;
    logic group_pending;

    `include "rename_model.svh"

    rename_stage #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .RENAME_WIDTH  (RENAME_WIDTH),
        .RETIRE_WIDTH  (RETIRE_WIDTH)
    ) dut_i (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_flush     (flush),
        .i_dsp_stall (dsp_stall),
        .i_dec_vld   (dec_vld),
        .i_dst_vld   (dst_vld),
        .i_dst_arch  (dst_arch),
        .i_src_vld   (src_vld),
        .i_src_arch  (src_arch),
        .i_ret_vld   (ret_vld),
        .i_ret_arch  (ret_arch),
        .i_ret_phys  (ret_phys),
        .o_src_phys  (src_phys),
        .o_dst_phys  (dst_phys),
        .o_ren_stall (ren_stall)
    );

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("error t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic clear_inputs();
        flush = 1'b0;
        dsp_stall = 1'b0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            dec_vld[k] = 1'b0;
            dst_vld[k] = 1'b0;
            dst_arch[k] = '0;
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                src_vld[k][s] = 1'b0;
                src_arch[k][s] = '0;
            end
        end
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            ret_vld[i] = 1'b0;
            ret_arch[i] = '0;
            ret_phys[i] = '0;
        end
    endtask

    task automatic new_group(input int arch_range);
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            dec_vld[k] = int'($urandom % 100) < 85;
            dst_vld[k] = int'($urandom % 100) < 80;
            dst_arch[k] = arch_reg_t'($urandom % arch_range);
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                src_vld[k][s] = int'($urandom % 100) < 75;
                src_arch[k][s] = arch_reg_t'($urandom % arch_range);
            end
        end
    endtask

    // Retirements come from the oldest in-flight ops
    task automatic pick_retires(input int ret_pct);
        ret_count = 0;
        if (int'($urandom % 100) < ret_pct) begin
            ret_count = int'($urandom % (RETIRE_WIDTH + 1));
        end
        if (ret_count > rob_arch.size()) begin
            ret_count = rob_arch.size();
        end
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            ret_vld[i] = i < ret_count;
            ret_arch[i] = (i < ret_count) ? arch_reg_t'(rob_arch[i]) : '0;
            ret_phys[i] = (i < ret_count) ? PHYS_BITS'(rob_phys[i]) : '0;
        end
    endtask

    task automatic drive_cycle(input int stall_pct, input int flush_pct, input int ret_pct,
                               input int arch_range);
        @(negedge clk);
        if (!group_pending) begin
            new_group(arch_range);
        end
        dsp_stall = int'($urandom % 100) < stall_pct;
        if (flush) begin
            flush = 1'b0;
        end else begin
            flush = int'($urandom % 100) < flush_pct;
        end
        pick_retires(ret_pct);
        #1;
    endtask

    task automatic finish_cycle();
        int   n_req;
        logic exp_stall;
        logic any_vld;
        n_req = plan_alloc();
        exp_stall = dsp_stall || (n_req > FREE_DEPTH - spec_off);
        check("o_ren_stall", int'(exp_stall), int'(ren_stall));
        any_vld = 1'b0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            any_vld = any_vld | dec_vld[k];
        end
        // Codes are only defined while the free list covers the group
        if (n_req <= FREE_DEPTH - spec_off) begin
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                if (dec_vld[k]) begin
                    for (int s = 0; s < SRCS_PER_UOP; s++) begin
                        if (src_vld[k][s]) begin
                            check($sformatf("o_src_phys[%0d][%0d]", k, s),
                                  expected_src(k, s), int'(src_phys[k][s]));
                        end
                    end
                    if (dst_vld[k]) begin
                        check($sformatf("o_dst_phys[%0d]", k), req_codes[k], int'(dst_phys[k]));
                    end
                end
            end
        end
        commit_retires(ret_count);
        if (flush) begin
            flush_state();
            group_pending = 1'b0;
        end else if (any_vld && !exp_stall) begin
            accept_group();
            group_pending = 1'b0;
        end else begin
            group_pending = any_vld;
        end
    endtask

    task automatic reset_test();
        int err0;
        err0 = errors;
        @(negedge clk);
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            dec_vld[k] = 1'b1;
            dst_vld[k] = 1'b1;
            dst_arch[k] = arch_reg_t'(20 + k);
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                src_vld[k][s] = 1'b1;
                src_arch[k][s] = arch_reg_t'($urandom % 16);
            end
        end
        dsp_stall = 1'b0;
        flush = 1'b0;
        ret_count = 0;
        #1;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            check($sformatf("o_dst_phys[%0d]", k), ARCH_REG_COUNT + k, int'(dst_phys[k]));
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                check($sformatf("o_src_phys[%0d][%0d]", k, s), int'(src_arch[k][s]),
                      int'(src_phys[k][s]));
            end
        end
        finish_cycle();
        tests++;
        $display("test after_reset: 1 cycle, %0d errors", errors - err0);
    endtask

    task automatic run_test(input string name, input int cycles, input int stall_pct,
                            input int flush_pct, input int ret_pct, input int arch_range);
        int err0;
        err0 = errors;
        for (int c = 0; c < cycles; c++) begin
            drive_cycle(stall_pct, flush_pct, ret_pct, arch_range);
            finish_cycle();
        end
        tests++;
        $display("test %s: %0d cycles, %0d errors", name, cycles, errors - err0);
    endtask

    initial begin
        void'($urandom(32'h5b3c1db4));
        clk = 1'b0;
        rst_n = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        ret_count = 0;
        group_pending = 1'b0;
        clear_inputs();
        reset_state();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_test();
        run_test("dependency", DEP_CYCLES, 0, 0, 60, 6);
        run_test("stall", STALL_CYCLES, 30, 0, 15, ARCH_REG_COUNT);
        run_test("retire_free", RETIRE_CYCLES, 10, 0, 80, 8);
        run_test("flush", FLUSH_CYCLES, 10, 8, 50, 12);

        @(negedge clk);
        clear_inputs();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/rename_stage.sv
`timescale 1ns/1ps

module rename_stage #(
    parameter int  NUM_PHYS_REGS = ren_cfg_pkg::DEF_NUM_PHYS_REGS,
    parameter int  RENAME_WIDTH  = ren_cfg_pkg::DEF_RENAME_WIDTH,
    parameter int  RETIRE_WIDTH  = ren_cfg_pkg::DEF_RETIRE_WIDTH,
    localparam int PHYS_BITS     = $clog2(NUM_PHYS_REGS)
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_dsp_stall,

    input  logic                 i_dec_vld  [RENAME_WIDTH],
    input  logic                 i_dst_vld  [RENAME_WIDTH],
    input  isa_pkg::arch_reg_t   i_dst_arch [RENAME_WIDTH],
    input  logic                 i_src_vld  [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],
    input  isa_pkg::arch_reg_t   i_src_arch [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],

    input  logic                 i_ret_vld  [RETIRE_WIDTH],
    input  isa_pkg::arch_reg_t   i_ret_arch [RETIRE_WIDTH],
    input  logic [PHYS_BITS-1:0] i_ret_phys [RETIRE_WIDTH],

    output logic [PHYS_BITS-1:0] o_src_phys [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],
    output logic [PHYS_BITS-1:0] o_dst_phys [RENAME_WIDTH],
    output logic                 o_ren_stall
);
    import isa_pkg::*;

    logic                 alloc_req  [RENAME_WIDTH];
    logic                 alloc_fire;
    logic [PHYS_BITS-1:0] map_phys   [RENAME_WIDTH][SRCS_PER_UOP];
    logic [PHYS_BITS-1:0] free_phys  [RETIRE_WIDTH];
    logic [PHYS_BITS-1:0] arch_next  [ARCH_REG_COUNT];

    // Slot needs a new register only for a live op that writes one
    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : g_req
        assign alloc_req[k] = i_dec_vld[k] & i_dst_vld[k];
    end

    free_list #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .RENAME_WIDTH  (RENAME_WIDTH),
        .RETIRE_WIDTH  (RETIRE_WIDTH)
    ) free_list_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_dsp_stall   (i_dsp_stall),
        .i_alloc_req   (alloc_req),
        .i_free_vld    (i_ret_vld),
        .i_free_phys   (free_phys),
        .o_alloc_phys  (o_dst_phys),
        .o_alloc_fire  (alloc_fire),
        .o_ren_stall   (o_ren_stall)
    );

    spec_map_table #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .RENAME_WIDTH  (RENAME_WIDTH)
    ) spec_map_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rd_arch     (i_src_arch),
        .i_alloc_fire  (alloc_fire),
        .i_alloc_req   (alloc_req),
        .i_dst_arch    (i_dst_arch),
        .i_alloc_phys  (o_dst_phys),
        .i_flush       (i_flush),
        .i_arch_next   (arch_next),
        .o_rd_phys     (map_phys)
    );

    // Same-group producers override the table read
    dep_bypass #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .RENAME_WIDTH  (RENAME_WIDTH)
    ) bypass_i (
        .i_src_vld     (i_src_vld),
        .i_src_arch    (i_src_arch),
        .i_dst_arch    (i_dst_arch),
        .i_alloc_req   (alloc_req),
        .i_map_phys    (map_phys),
        .i_alloc_phys  (o_dst_phys),
        .o_src_phys    (o_src_phys)
    );

    arch_map_table #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .RETIRE_WIDTH  (RETIRE_WIDTH)
    ) arch_map_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_ret_vld     (i_ret_vld),
        .i_ret_arch    (i_ret_arch),
        .i_ret_phys    (i_ret_phys),
        .o_free_phys   (free_phys),
        .o_arch_next   (arch_next)
    );

endmodule

// File: rename/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int  NUM_PHYS_REGS = ren_cfg_pkg::DEF_NUM_PHYS_REGS,
    parameter int  RENAME_WIDTH  = ren_cfg_pkg::DEF_RENAME_WIDTH,
    parameter int  RETIRE_WIDTH  = ren_cfg_pkg::DEF_RETIRE_WIDTH,
    localparam int PHYS_BITS     = $clog2(NUM_PHYS_REGS)
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_dsp_stall,
    input  logic                 i_alloc_req  [RENAME_WIDTH],
    input  logic                 i_free_vld   [RETIRE_WIDTH],
    input  logic [PHYS_BITS-1:0] i_free_phys  [RETIRE_WIDTH],
    output logic [PHYS_BITS-1:0] o_alloc_phys [RENAME_WIDTH],
    output logic                 o_alloc_fire,
    output logic                 o_ren_stall
);
    import isa_pkg::*;

    localparam int FL_DEPTH = NUM_PHYS_REGS - ARCH_REG_COUNT;
    // Pointers run over twice the depth so full and empty differ
    localparam int RING     = 2 * FL_DEPTH;
    localparam int PTR_BITS = $clog2(RING);
    localparam int IDX_BITS = $clog2(FL_DEPTH);

    logic [PHYS_BITS-1:0] fifo_q [FL_DEPTH];
    logic [PTR_BITS-1:0]  head_q;
    logic [PTR_BITS-1:0]  tail_q;
    logic [PTR_BITS-1:0]  cmt_q;
    logic [PTR_BITS-1:0]  head_d;
    logic [PTR_BITS-1:0]  tail_d;
    logic [PTR_BITS-1:0]  cmt_d;
    int                   avail_cnt;
    int                   alloc_num;
    int                   ret_num;
    int                   alloc_off [RENAME_WIDTH];
    int                   ret_off   [RETIRE_WIDTH];

    function automatic logic [PTR_BITS-1:0] ptr_add(input logic [PTR_BITS-1:0] ptr, input int n);
        int sum;
        sum = int'(ptr) + n;
        if (sum >= RING) begin
            sum = sum - RING;
        end
        return PTR_BITS'(sum);
    endfunction

    function automatic logic [IDX_BITS-1:0] ptr_idx(input logic [PTR_BITS-1:0] ptr);
        int idx;
        idx = int'(ptr);
        if (idx >= FL_DEPTH) begin
            idx = idx - FL_DEPTH;
        end
        return IDX_BITS'(idx);
    endfunction

    // Slot offsets within the group, requesters packed in slot order
    always_comb begin
        alloc_num = 0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            alloc_off[k] = alloc_num;
            if (i_alloc_req[k]) begin
                alloc_num = alloc_num + 1;
            end
        end
        ret_num = 0;
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            ret_off[i] = ret_num;
            if (i_free_vld[i]) begin
                ret_num = ret_num + 1;
            end
        end
    end

    always_comb begin
        avail_cnt = int'(tail_q) - int'(head_q);
        if (avail_cnt < 0) begin
            avail_cnt = avail_cnt + RING;
        end
    end

    assign o_ren_stall = i_dsp_stall || (alloc_num > avail_cnt);
    // Groups without destinations change no rename state
    assign o_alloc_fire = (alloc_num != 0) && !o_ren_stall && !i_flush;

    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            o_alloc_phys[k] = fifo_q[ptr_idx(ptr_add(head_q, alloc_off[k]))];
        end
    end

    always_comb begin
        tail_d = ptr_add(tail_q, ret_num);
        cmt_d  = ptr_add(cmt_q, ret_num);
        if (i_flush) begin
            head_d = cmt_d;
        end else if (o_alloc_fire) begin
            head_d = ptr_add(head_q, alloc_num);
        end else begin
            head_d = head_q;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_q <= '0;
            cmt_q  <= '0;
            tail_q <= PTR_BITS'(FL_DEPTH);
        end else begin
            head_q <= head_d;
            cmt_q  <= cmt_d;
            tail_q <= tail_d;
        end
    end

    // Starts full with every code above the architectural range
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int e = 0; e < FL_DEPTH; e++) begin
                fifo_q[e] <= PHYS_BITS'(ARCH_REG_COUNT + e);
            end
        end else begin
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (i_free_vld[i]) begin
                    fifo_q[ptr_idx(ptr_add(tail_q, ret_off[i]))] <= i_free_phys[i];
                end
            end
        end
    end

endmodule

// File: rename/arch_map_table.sv
`timescale 1ns/1ps

module arch_map_table #(
    parameter int  NUM_PHYS_REGS = ren_cfg_pkg::DEF_NUM_PHYS_REGS,
    parameter int  RETIRE_WIDTH  = ren_cfg_pkg::DEF_RETIRE_WIDTH,
    localparam int PHYS_BITS     = $clog2(NUM_PHYS_REGS)
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_ret_vld   [RETIRE_WIDTH],
    input  isa_pkg::arch_reg_t   i_ret_arch  [RETIRE_WIDTH],
    input  logic [PHYS_BITS-1:0] i_ret_phys  [RETIRE_WIDTH],
    output logic [PHYS_BITS-1:0] o_free_phys [RETIRE_WIDTH],
    output logic [PHYS_BITS-1:0] o_arch_next [isa_pkg::ARCH_REG_COUNT]
);
    import isa_pkg::*;

    logic [PHYS_BITS-1:0] amap_q [ARCH_REG_COUNT];
    logic                 killed [RETIRE_WIDTH];

    // Slot is shadowed by a younger retire to the same register
    always_comb begin
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            killed[i] = 1'b0;
            for (int j = i + 1; j < RETIRE_WIDTH; j++) begin
                if (i_ret_vld[j] && (i_ret_arch[j] == i_ret_arch[i])) begin
                    killed[i] = 1'b1;
                end
            end
        end
    end

    // A shadowed slot never lands in the table, so its own code goes back
    always_comb begin
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            if (killed[i]) begin
                o_free_phys[i] = i_ret_phys[i];
            end else begin
                o_free_phys[i] = amap_q[i_ret_arch[i]];
            end
        end
    end

    always_comb begin
        o_arch_next = amap_q;
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            if (i_ret_vld[i] && !killed[i]) begin
                o_arch_next[i_ret_arch[i]] = i_ret_phys[i];
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < ARCH_REG_COUNT; r++) begin
                amap_q[r] <= PHYS_BITS'(r);
            end
        end else begin
            amap_q <= o_arch_next;
        end
    end

endmodule

// File: rename/spec_map_table.sv
`timescale 1ns/1ps

module spec_map_table #(
    parameter int  NUM_PHYS_REGS = ren_cfg_pkg::DEF_NUM_PHYS_REGS,
    parameter int  RENAME_WIDTH  = ren_cfg_pkg::DEF_RENAME_WIDTH,
    localparam int PHYS_BITS     = $clog2(NUM_PHYS_REGS)
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  isa_pkg::arch_reg_t   i_rd_arch    [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],
    input  logic                 i_alloc_fire,
    input  logic                 i_alloc_req  [RENAME_WIDTH],
    input  isa_pkg::arch_reg_t   i_dst_arch   [RENAME_WIDTH],
    input  logic [PHYS_BITS-1:0] i_alloc_phys [RENAME_WIDTH],
    input  logic                 i_flush,
    input  logic [PHYS_BITS-1:0] i_arch_next  [isa_pkg::ARCH_REG_COUNT],
    output logic [PHYS_BITS-1:0] o_rd_phys    [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP]
);
    import isa_pkg::*;

    logic [PHYS_BITS-1:0] smap_q [ARCH_REG_COUNT];
    logic [PHYS_BITS-1:0] smap_d [ARCH_REG_COUNT];

    // Source lookup, bypass for same-group producers happens downstream
    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                o_rd_phys[k][s] = smap_q[i_rd_arch[k][s]];
            end
        end
    end

    always_comb begin
        smap_d = smap_q;
        if (i_flush) begin
            // Restore from committed state including this cycle's retires
            smap_d = i_arch_next;
        end else if (i_alloc_fire) begin
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                if (i_alloc_req[k]) begin
                    smap_d[i_dst_arch[k]] = i_alloc_phys[k];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < ARCH_REG_COUNT; r++) begin
                smap_q[r] <= PHYS_BITS'(r);
            end
        end else begin
            smap_q <= smap_d;
        end
    end

endmodule

// File: rename/dep_bypass.sv
`timescale 1ns/1ps

module dep_bypass #(
    parameter int  NUM_PHYS_REGS = ren_cfg_pkg::DEF_NUM_PHYS_REGS,
    parameter int  RENAME_WIDTH  = ren_cfg_pkg::DEF_RENAME_WIDTH,
    localparam int PHYS_BITS     = $clog2(NUM_PHYS_REGS)
) (
    input  logic                 i_src_vld    [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],
    input  isa_pkg::arch_reg_t   i_src_arch   [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],
    input  isa_pkg::arch_reg_t   i_dst_arch   [RENAME_WIDTH],
    input  logic                 i_alloc_req  [RENAME_WIDTH],
    input  logic [PHYS_BITS-1:0] i_map_phys   [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP],
    input  logic [PHYS_BITS-1:0] i_alloc_phys [RENAME_WIDTH],
    output logic [PHYS_BITS-1:0] o_src_phys   [RENAME_WIDTH][isa_pkg::SRCS_PER_UOP]
);
    import isa_pkg::*;

    // match[k][s][j]: source s of slot k reads the destination of older slot j
    logic match [RENAME_WIDTH][SRCS_PER_UOP][RENAME_WIDTH];

    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                for (int j = 0; j < RENAME_WIDTH; j++) begin
                    match[k][s][j] = (j < k)
                                  && i_alloc_req[j]
                                  && i_src_vld[k][s]
                                  && (i_src_arch[k][s] == i_dst_arch[j]);
                end
            end
        end
    end

    // Later hits overwrite earlier ones so the youngest producer wins
    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            for (int s = 0; s < SRCS_PER_UOP; s++) begin
                o_src_phys[k][s] = i_map_phys[k][s];
                for (int j = 0; j < RENAME_WIDTH; j++) begin
                    if (match[k][s][j]) begin
                        o_src_phys[k][s] = i_alloc_phys[j];
                    end
                end
            end
        end
    end

endmodule

// File: common/ren_cfg_pkg.sv
package ren_cfg_pkg;

    // Physical register file size, must stay above the architectural count
    localparam int DEF_NUM_PHYS_REGS = 64;

    // Group widths at the rename and retire boundaries
    localparam int DEF_RENAME_WIDTH = 4;
    localparam int DEF_RETIRE_WIDTH = 4;

endpackage

// File: common/isa_pkg.sv
package isa_pkg;

    // Integer register file as seen by software
    localparam int ARCH_REG_COUNT = 32;
    localparam int ARCH_REG_BITS  = 5;

    typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;

    // Source operands carried by one micro-op
    localparam int SRCS_PER_UOP = 2;

endpackage
